/* verilog/sms_cart_pkg.sv */
package sms_cart_pkg;

	// ==============================
	// Download indices from the host
	// ==============================
	localparam logic [7:0] IDX_SMS   = 8'd1;
	localparam logic [7:0] IDX_GG    = 8'd2;
	localparam logic [7:0] IDX_CHEAT = 8'd255;

	// Cartridge identifier window
	localparam logic [24:0] CART_ID_ADDR = 25'h0007FFC;   // First of four id bytes
	localparam logic [24:0] CART_ID_END  = 25'h0008000;   // Compare fires here

	// Ys (Japan) needs the VDP version 1 graphics fix
	localparam logic [31:0] QUIRK_ID = 32'h1370014F;

	// ==============================
	// Cheat records
	// ==============================
	// Code fields: flags 127..96, address 95..64, compare 63..32, replace 31..0
	localparam logic [4:0] CHEAT_BYTES = 5'd16;
	localparam logic [7:0] CHEAT_W     = 8'd128;

	// ROM write handshake
	typedef enum logic {
		LD_IDLE,
		LD_WAIT_ACK
	} loader_state_t;

endpackage

/* verilog/sms_host_pkg.sv */
package sms_host_pkg;

	// ==============================
	// Wishbone register block
	// ==============================
	localparam logic [5:0] WB_DW = 6'd32;
	localparam logic [2:0] WB_AW = 3'd2;

	typedef enum logic [1:0] {
		REG_CTRL,     // Bit 0 cheat enable
		REG_STATUS,
		REG_MASK,
		REG_CODES
	} reg_addr_t;

	// Status bit positions
	localparam logic [4:0] ST_BUSY  = 5'd0;
	localparam logic [4:0] ST_GG    = 5'd1;
	localparam logic [4:0] ST_QUIRK = 5'd2;

	// ==============================
	// Clock enable sequencer
	// ==============================
	localparam logic [4:0] CE_STEPS = 5'd30;

	// One bit per step, set where the enable fires
	localparam logic [29:0] CE_VDP_STEPS = 30'h21084210;   // 4, 9, 14, 19, 24, 29
	localparam logic [29:0] CE_PIX_STEPS = 30'h20080200;   // 9, 19, 29
	localparam logic [29:0] CE_CPU_STEPS = 30'h01000200;   // 9, 24

endpackage

/* verilog/sms_ce_gen.sv */
`timescale 1ns/1ps

module sms_ce_gen (
	input  logic clk_sys,
	input  logic RESET,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix
);

	logic [4:0] step;
	logic       last_step;

	assign last_step = (step == sms_host_pkg::CE_STEPS - 5'd1);

	// Step counter, 0..29
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			step <= '0;
		end else if (last_step) begin
			step <= '0;
		end else begin
			step <= step + 5'd1;
		end
	end

	// Decoders are registered, so every enable trails its step by one clock.
	// All three come from the same counter, which keeps CPU and pixel
	// enables locked to the VDP phase
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_cpu <= 1'b0;
		end else begin
			ce_vdp <= sms_host_pkg::CE_VDP_STEPS[step];   // Div 5
			ce_pix <= sms_host_pkg::CE_PIX_STEPS[step];   // Div 10
			ce_cpu <= sms_host_pkg::CE_CPU_STEPS[step];   // Div 15
		end
	end

endmodule

/* verilog/sms_cart_loader.sv */
`timescale 1ns/1ps

module sms_cart_loader #(
	parameter integer ROM_ADDR_W = 22
) (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  ioctl_download,
	input  logic [7:0]            ioctl_index,
	input  logic                  ioctl_wr,
	input  logic [24:0]           ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	input  logic                  rom_ack,
	output logic                  ioctl_wait,
	output logic [ROM_ADDR_W-1:0] rom_addr,
	output logic [7:0]            rom_data,
	output logic                  rom_req,
	output logic [ROM_ADDR_W-1:0] cart_mask,
	output logic                  busy,
	output logic                  gg,
	output logic                  quirk
);

	sms_cart_pkg::loader_state_t state;

	logic        cart_dl;
	logic        cart_dl_q;
	logic        cart_start;
	logic        cart_wr;
	logic [31:0] cart_id;

	assign cart_dl = ioctl_download &&
		(ioctl_index == sms_cart_pkg::IDX_SMS || ioctl_index == sms_cart_pkg::IDX_GG);
	assign cart_start = cart_dl && !cart_dl_q;
	assign cart_wr    = ioctl_wr && cart_dl;
	assign busy       = cart_dl_q;
	assign ioctl_wait = (state == sms_cart_pkg::LD_WAIT_ACK);   // Host held off

	// ==============================
	// ROM write handshake
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state     <= sms_cart_pkg::LD_IDLE;
			cart_dl_q <= 1'b0;
			rom_req   <= 1'b0;
			rom_addr  <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			case (state)
				sms_cart_pkg::LD_IDLE: begin
					if (cart_wr) begin
						rom_req <= ~rom_req;   // Toggle requests one write
						state   <= sms_cart_pkg::LD_WAIT_ACK;
					end
				end
				sms_cart_pkg::LD_WAIT_ACK: begin
					// Memory is done once ack catches up with req
					if (rom_ack == rom_req) begin
						rom_addr <= rom_addr + 1'b1;
						state    <= sms_cart_pkg::LD_IDLE;
					end
				end
			endcase
			if (cart_start)
				rom_addr <= '0;
		end
	end

	// Byte and identifier capture
	always_ff @(posedge clk_sys) begin
		if (cart_wr && state == sms_cart_pkg::LD_IDLE)
			rom_data <= ioctl_dout;
		if (cart_wr && ioctl_addr[24:2] == sms_cart_pkg::CART_ID_ADDR[24:2])
			cart_id <= {cart_id[23:0], ioctl_dout};   // Big-endian
	end

	// ==============================
	// Image size, console type, quirk
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_mask <= '0;
			gg        <= 1'b0;
			quirk     <= 1'b0;
		end else begin
			if (cart_start)
				quirk <= 1'b0;
			if (cart_wr) begin
				gg <= (ioctl_index == sms_cart_pkg::IDX_GG);
				if (ioctl_addr == '0)
					cart_mask <= '0;   // New image
				else
					cart_mask <= cart_mask | ioctl_addr[ROM_ADDR_W-1:0];
				if (ioctl_addr == sms_cart_pkg::CART_ID_END && cart_id == sms_cart_pkg::QUIRK_ID)
					quirk <= 1'b1;
			end
		end
	end

endmodule

/* verilog/sms_cheat_asm.sv */
`timescale 1ns/1ps

module sms_cheat_asm (
	input  logic                               clk_sys,
	input  logic                               RESET,
	input  logic                               ioctl_download,
	input  logic [7:0]                         ioctl_index,
	input  logic                               ioctl_wr,
	input  logic [3:0]                         ioctl_addr,
	input  logic [7:0]                         ioctl_dout,
	input  logic                               cheats_en,
	output logic [sms_cart_pkg::CHEAT_W-1:0]   cheat_code,
	output logic                               cheat_valid,
	output logic [7:0]                         code_count
);

	logic code_dl;
	logic code_dl_q;
	logic code_wr;
	logic last_byte;
	logic [6:0] byte_pos;

	assign code_dl   = ioctl_download && ioctl_index == sms_cart_pkg::IDX_CHEAT;
	assign code_wr   = ioctl_wr && code_dl;
	assign last_byte = (ioctl_addr == 4'(sms_cart_pkg::CHEAT_BYTES - 5'd1));

	// Field order is flags first, each field LSB first
	assign byte_pos = {~ioctl_addr[3:2], ioctl_addr[1:0], 3'b000};

	always_ff @(posedge clk_sys) begin
		if (code_wr)
			cheat_code[byte_pos +: 8] <= ioctl_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_dl_q   <= 1'b0;
			cheat_valid <= 1'b0;
			code_count  <= '0;
		end else begin
			code_dl_q   <= code_dl;
			cheat_valid <= 1'b0;
			if (code_dl && !code_dl_q)
				code_count <= '0;   // Fresh cheat file
			else if (code_wr && last_byte) begin
				cheat_valid <= cheats_en;
				code_count  <= code_count + 8'd1;
			end
		end
	end

endmodule

/* verilog/sms_host_regs.sv */
`timescale 1ns/1ps

module sms_host_regs #(
	parameter integer ROM_ADDR_W = 22
) (
	input  logic                           clk_sys,
	input  logic                           RESET,
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  logic [sms_host_pkg::WB_AW-1:0] wb_adr,
	input  logic [sms_host_pkg::WB_DW-1:0] wb_dat_w,
	input  logic                           busy,
	input  logic                           gg,
	input  logic                           quirk,
	input  logic [ROM_ADDR_W-1:0]          cart_mask,
	input  logic [7:0]                     code_count,
	output logic [sms_host_pkg::WB_DW-1:0] wb_dat_r,
	output logic                           wb_ack,
	output logic                           cheats_en
);

	sms_host_pkg::reg_addr_t reg_sel;

	logic                           access;
	logic [sms_host_pkg::WB_DW-1:0] rd_data;

	assign reg_sel = sms_host_pkg::reg_addr_t'(wb_adr);
	assign access  = wb_cyc && wb_stb && !wb_ack;   // One ack per strobe

	// ==============================
	// Read mux
	// ==============================
	always_comb begin
		rd_data = '0;
		case (reg_sel)
			sms_host_pkg::REG_CTRL:   rd_data[0] = cheats_en;
			sms_host_pkg::REG_STATUS: begin
				rd_data[sms_host_pkg::ST_BUSY]  = busy;
				rd_data[sms_host_pkg::ST_GG]    = gg;
				rd_data[sms_host_pkg::ST_QUIRK] = quirk;
			end
			sms_host_pkg::REG_MASK:   rd_data[ROM_ADDR_W-1:0] = cart_mask;
			sms_host_pkg::REG_CODES:  rd_data[7:0] = code_count;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (access)
			wb_dat_r <= rd_data;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wb_ack    <= 1'b0;
			cheats_en <= 1'b0;
		end else begin
			wb_ack <= access;
			// Only CTRL is writable
			if (access && wb_we && reg_sel == sms_host_pkg::REG_CTRL)
				cheats_en <= wb_dat_w[0];
		end
	end

endmodule

/* verilog/sms_loader_top.sv */
`timescale 1ns/1ps

module sms_loader_top #(
	parameter integer ROM_ADDR_W = 22
) (
	input  logic                             clk_sys,
	input  logic                             RESET,
	output logic                             ce_cpu,
	output logic                             ce_vdp,
	output logic                             ce_pix,
	// Host download port
	input  logic                             ioctl_download,
	input  logic [7:0]                       ioctl_index,
	input  logic                             ioctl_wr,
	input  logic [24:0]                      ioctl_addr,
	input  logic [7:0]                       ioctl_dout,
	output logic                             ioctl_wait,
	// Cartridge ROM
	output logic [ROM_ADDR_W-1:0]            rom_addr,
	output logic [7:0]                       rom_data,
	output logic                             rom_req,
	input  logic                             rom_ack,
	// Cheat engine
	output logic [sms_cart_pkg::CHEAT_W-1:0] cheat_code,
	output logic                             cheat_valid,
	// Wishbone
	input  logic                             wb_cyc,
	input  logic                             wb_stb,
	input  logic                             wb_we,
	input  logic [sms_host_pkg::WB_AW-1:0]   wb_adr,
	input  logic [sms_host_pkg::WB_DW-1:0]   wb_dat_w,
	output logic [sms_host_pkg::WB_DW-1:0]   wb_dat_r,
	output logic                             wb_ack
);

	logic [ROM_ADDR_W-1:0] cart_mask;
	logic                  busy;
	logic                  gg;
	logic                  quirk;
	logic                  cheats_en;
	logic [7:0]            code_count;

	sms_ce_gen u_ce_gen (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix)
	);

	sms_cart_loader #(.ROM_ADDR_W(ROM_ADDR_W)) u_cart_loader (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom_ack        (rom_ack),
		.ioctl_wait     (ioctl_wait),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data),
		.rom_req        (rom_req),
		.cart_mask      (cart_mask),
		.busy           (busy),
		.gg             (gg),
		.quirk          (quirk)
	);

	sms_cheat_asm u_cheat_asm (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr[3:0]),   // Offset within a record
		.ioctl_dout     (ioctl_dout),
		.cheats_en      (cheats_en),
		.cheat_code     (cheat_code),
		.cheat_valid    (cheat_valid),
		.code_count     (code_count)
	);

	sms_host_regs #(.ROM_ADDR_W(ROM_ADDR_W)) u_host_regs (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.busy       (busy),
		.gg         (gg),
		.quirk      (quirk),
		.cart_mask  (cart_mask),
		.code_count (code_count),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.cheats_en  (cheats_en)
	);

endmodule

/* bench/sms_loader_sva.sv */
`timescale 1ns/1ps

module sms_loader_sva (
	input logic clk_sys,
	input logic RESET,
	input logic ce_cpu,
	input logic ce_vdp,
	input logic ce_pix,
	input logic ioctl_wait,
	input logic rom_req,
	input logic rom_ack,
	input logic wb_ack
);

	int fail_count = 0;   // Failed assertions so far

	// ==============================
	// Bus handshakes
	// ==============================
	wb_ack_single: assert property (@(posedge clk_sys) disable iff (RESET)
		wb_ack |=> !wb_ack)
	else begin
		fail_count++;
		$error("wb_ack lasted more than one cycle");
	end

	// Host released only after the memory caught up
	wait_release: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(ioctl_wait) |-> $past(rom_ack == rom_req))
	else begin
		fail_count++;
		$error("ioctl_wait fell while rom_ack differed from rom_req");
	end

	// ==============================
	// Clock enables
	// ==============================
	pix_on_vdp: assert property (@(posedge clk_sys) disable iff (RESET)
		ce_pix |-> ce_vdp)
	else begin
		fail_count++;
		$error("ce_pix without ce_vdp");
	end

	quiet_in_reset: assert property (@(posedge clk_sys)
		RESET ##1 RESET |-> !(ce_cpu || ce_vdp || ce_pix))
	else begin
		fail_count++;
		$error("clock enable high during reset");
	end

endmodule

bind sms_loader_top sms_loader_sva u_sva (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.ce_cpu     (ce_cpu),
	.ce_vdp     (ce_vdp),
	.ce_pix     (ce_pix),
	.ioctl_wait (ioctl_wait),
	.rom_req    (rom_req),
	.rom_ack    (rom_ack),
	.wb_ack     (wb_ack)
);

/* bench/tb_sms_loader.sv */
`timescale 1ns/1ps

module tb_sms_loader;

	localparam integer ROM_ADDR_W = 22;

	logic                             clk_sys;
	logic                             RESET;
	logic                             ce_cpu;
	logic                             ce_vdp;
	logic                             ce_pix;
	logic                             ioctl_download;
	logic [7:0]                       ioctl_index;
	logic                             ioctl_wr;
	logic [24:0]                      ioctl_addr;
	logic [7:0]                       ioctl_dout;
	logic                             ioctl_wait;
	logic [ROM_ADDR_W-1:0]            rom_addr;
	logic [7:0]                       rom_data;
	logic                             rom_req;
	logic                             rom_ack;
	logic [sms_cart_pkg::CHEAT_W-1:0] cheat_code;
	logic                             cheat_valid;
	logic                             wb_cyc;
	logic                             wb_stb;
	logic                             wb_we;
	logic [sms_host_pkg::WB_AW-1:0]   wb_adr;
	logic [sms_host_pkg::WB_DW-1:0]   wb_dat_w;
	logic [sms_host_pkg::WB_DW-1:0]   wb_dat_r;
	logic                             wb_ack;

	logic [31:0]  lfsr;
	logic [7:0]   rom_mem [int unsigned];   // ROM model contents
	logic [7:0]   sent [0:63];
	logic [127:0] codes_seen [$];
	logic         rom_req_q;
	int           checks;
	int           errors;
	int           req_toggles;
	int           valid_pulses;

	sms_loader_top #(.ROM_ADDR_W(ROM_ADDR_W)) u_sms_loader_top (.*);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	// Request toggles and released cheat codes sampled mid-cycle
	always @(negedge clk_sys) begin
		if (!RESET && rom_req !== rom_req_q)
			req_toggles++;
		rom_req_q = rom_req;
		if (cheat_valid === 1'b1) begin
			valid_pulses++;
			codes_seen.push_back(cheat_code);
		end
	end

	// ==============================
	// Helpers
	// ==============================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // x^32+x^22+x^2+x+1
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr  = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	// Offsets 0..15 fill flags, address, compare and replace in turn with each field LSB first
	function automatic logic [127:0] pack_code(input logic [127:0] rec);
		logic [127:0] code;
		code = '0;
		for (int f = 0; f < 4; f++)
			for (int k = 0; k < 4; k++)
				code[96 - 32*f + 8*k +: 8] = rec[8*(4*f + k) +: 8];
		return code;
	endfunction

	function automatic logic [31:0] status_word(input logic busy, input logic gg,
		input logic quirk);
		logic [31:0] word;
		word = '0;
		word[sms_host_pkg::ST_BUSY]  = busy;
		word[sms_host_pkg::ST_GG]    = gg;
		word[sms_host_pkg::ST_QUIRK] = quirk;
		return word;
	endfunction

	task automatic close_run();
		int sva_fails;
		sva_fails = u_sms_loader_top.u_sva.fail_count;
		$display("Checks: %0d, value errors: %0d, assertion failures: %0d",
			checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		errors++;
		close_run();
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// ==============================
	// Wishbone master
	// ==============================
	task automatic wb_access(input logic we, input logic [sms_host_pkg::WB_AW-1:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int wait_cycles;
		wb_cyc      = 1'b1;
		wb_stb      = 1'b1;
		wb_we       = we;
		wb_adr      = adr;
		wb_dat_w    = wdata;
		wait_cycles = 0;
		do begin
			@(negedge clk_sys);
			wait_cycles++;
		end while (wb_ack !== 1'b1 && wait_cycles < 4);
		if (wb_ack !== 1'b1)
			fail_timeout("wb_ack");
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic reg_read(input logic [sms_host_pkg::WB_AW-1:0] adr,
		output logic [31:0] rdata);
		wb_access(1'b0, adr, 32'h0, rdata);
	endtask

	task automatic reg_write(input logic [sms_host_pkg::WB_AW-1:0] adr,
		input logic [31:0] wdata);
		logic [31:0] unused;
		wb_access(1'b1, adr, wdata, unused);
	endtask

	// ==============================
	// Host download port
	// ==============================
	task automatic start_download(input logic [7:0] index);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic pulse_write(input logic [24:0] addr, input logic [7:0] data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr   = 1'b0;
	endtask

	// One cartridge byte with the ROM memory answering after a random delay
	task automatic cart_write(input logic [24:0] addr, input logic [7:0] data,
		input int index);
		logic [31:0] delay;
		int          wait_cycles;
		pulse_write(addr, data);
		wait_cycles = 0;
		while (rom_req === rom_ack && wait_cycles < 4) begin
			@(negedge clk_sys);
			wait_cycles++;
		end
		if (rom_req === rom_ack)
			fail_timeout("rom_req toggle");
		check_value($sformatf("rom_addr of byte %0d", index), index, rom_addr);
		check_value($sformatf("rom_data of byte %0d", index), data, rom_data);
		draw_bits(3, delay);
		repeat (delay) begin
			check_value("ioctl_wait before ack", 1, ioctl_wait);
			@(negedge clk_sys);
		end
		check_value("ioctl_wait before ack", 1, ioctl_wait);
		rom_mem[rom_addr] = rom_data;
		rom_ack = rom_req;
		wait_cycles = 0;
		do begin
			@(negedge clk_sys);
			wait_cycles++;
		end while (ioctl_wait !== 1'b0 && wait_cycles < 4);
		if (ioctl_wait !== 1'b0)
			fail_timeout("ioctl_wait release");
	endtask

	task automatic send_id_block(input logic [31:0] id);
		start_download(sms_cart_pkg::IDX_SMS);
		for (int i = 0; i < 4; i++)
			cart_write(sms_cart_pkg::CART_ID_ADDR + 25'(i), id[8*(3-i) +: 8], i);
		cart_write(sms_cart_pkg::CART_ID_END, 8'h00, 4);
		end_download();
	endtask

	task automatic send_record(input int number, output logic [127:0] rec);
		logic [31:0] value;
		for (int off = 0; off < 16; off++) begin
			draw_bits(8, value);
			rec[8*off +: 8] = value[7:0];
			pulse_write(25'(16*number + off), value[7:0]);
			@(negedge clk_sys);   // Gap between strobes
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		int           n_vdp;
		int           n_pix;
		int           n_cpu;
		logic [31:0]  value;
		logic [31:0]  rdata;
		logic [24:0]  addr;
		logic [127:0] rec0;
		logic [127:0] rec1;
		logic [127:0] rec2;

		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		rom_ack        = 1'b0;
		wb_cyc         = 1'b0;
		wb_stb         = 1'b0;
		wb_we          = 1'b0;
		wb_adr         = '0;
		wb_dat_w       = '0;
		lfsr           = 32'h884ac304;
		rom_req_q      = 1'b0;
		checks         = 0;
		errors         = 0;
		req_toggles    = 0;
		valid_pulses   = 0;
		repeat (8) @(negedge clk_sys);
		RESET = 1'b0;

		// Enable rates over ten windows of 30 cycles
		for (int w = 0; w < 10; w++) begin
			n_vdp = 0;
			n_pix = 0;
			n_cpu = 0;
			repeat (30) begin
				@(negedge clk_sys);
				n_vdp += ce_vdp;
				n_pix += ce_pix;
				n_cpu += ce_cpu;
				if (ce_cpu)
					check_value("ce_cpu with ce_vdp", 1, ce_vdp);
			end
			check_value("ce_vdp per window", 6, n_vdp);
			check_value("ce_pix per window", 3, n_pix);
			check_value("ce_cpu per window", 2, n_cpu);
		end

		// SMS image of 64 random bytes
		req_toggles = 0;
		start_download(sms_cart_pkg::IDX_SMS);
		for (int i = 0; i < 64; i++) begin
			draw_bits(8, value);
			sent[i] = value[7:0];
			cart_write(25'(i), value[7:0], i);
		end
		end_download();
		check_value("rom_req toggles", 64, req_toggles);
		for (int i = 0; i < 64; i++)
			check_value($sformatf("rom byte %0d", i), sent[i], rom_mem[i]);
		reg_read(sms_host_pkg::REG_MASK, rdata);
		check_value("mask after sms", 63, rdata);
		reg_read(sms_host_pkg::REG_STATUS, rdata);
		check_value("status after sms", status_word(1'b0, 1'b0, 1'b0), rdata);

		// Short GG image reaching 1FFh
		start_download(sms_cart_pkg::IDX_GG);
		for (int i = 0; i < 16; i++) begin
			addr = (i < 8) ? 25'(i) : 25'(i + 'h1F0);
			draw_bits(8, value);
			cart_write(addr, value[7:0], i);
		end
		end_download();
		reg_read(sms_host_pkg::REG_MASK, rdata);
		check_value("mask after gg", 32'h1FF, rdata);
		reg_read(sms_host_pkg::REG_STATUS, rdata);
		check_value("status after gg", status_word(1'b0, 1'b1, 1'b0), rdata);

		// Identifier of the VDP quirk title and then a near miss
		send_id_block(32'h1370014F);
		reg_read(sms_host_pkg::REG_STATUS, rdata);
		check_value("status with quirk id", status_word(1'b0, 1'b0, 1'b1), rdata);
		send_id_block(32'h1370014E);
		reg_read(sms_host_pkg::REG_STATUS, rdata);
		check_value("status with other id", status_word(1'b0, 1'b0, 1'b0), rdata);

		// Cheat records while enabled and then disabled
		reg_write(sms_host_pkg::REG_CTRL, 32'h1);
		valid_pulses = 0;
		codes_seen.delete();
		start_download(sms_cart_pkg::IDX_CHEAT);
		send_record(0, rec0);
		send_record(1, rec1);
		@(negedge clk_sys);
		check_value("cheat_valid pulses enabled", 2, valid_pulses);
		if (codes_seen.size() == 2) begin
			check_value("cheat_code 0", pack_code(rec0), codes_seen[0]);
			check_value("cheat_code 1", pack_code(rec1), codes_seen[1]);
		end
		reg_read(sms_host_pkg::REG_CODES, rdata);
		check_value("codes after two", 2, rdata);
		reg_write(sms_host_pkg::REG_CTRL, 32'h0);
		send_record(2, rec2);
		end_download();
		check_value("cheat_valid pulses disabled", 2, valid_pulses);
		reg_read(sms_host_pkg::REG_CODES, rdata);
		check_value("codes after three", 3, rdata);

		close_run();
	end

endmodule

/* list.f */
verilog/sms_cart_pkg.sv
verilog/sms_host_pkg.sv
verilog/sms_ce_gen.sv
verilog/sms_cart_loader.sv
verilog/sms_cheat_asm.sv
verilog/sms_host_regs.sv
verilog/sms_loader_top.sv
bench/sms_loader_sva.sv
bench/tb_sms_loader.sv

/* Bender.yml */
package:
  name: sms_loader

sources:
  - verilog/sms_cart_pkg.sv
  - verilog/sms_host_pkg.sv
  - verilog/sms_ce_gen.sv
  - verilog/sms_cart_loader.sv
  - verilog/sms_cheat_asm.sv
  - verilog/sms_host_regs.sv
  - verilog/sms_loader_top.sv
  - target: test
    files:
      - bench/sms_loader_sva.sv
      - bench/tb_sms_loader.sv
